// ==== fp_cvt.f ====
fp_cvt_pkg.sv
fp_stage_if.sv
fp_cvt_unpack.sv
fp_cvt_normalize.sv
fp_cvt_denorm_shift.sv
fp_cvt_round.sv
fp_cvt_result_select.sv
fp_cvt_top.sv
fp_cvt_tb.sv

// ==== fp_cvt_denorm_shift.sv ====
`timescale 1ns/1ps

module fp_cvt_denorm_shift (
  input logic     i_clk,
  input logic     i_rst,
  fp_stage_if.dst i_stg,
  fp_stage_if.src o_stg
);
  import fp_cvt_pkg::*;

  logic signed [12:0] exp_in;
  logic signed [12:0] shamt_full;
  logic [5:0]         shamt;
  logic [26:0]        ext;
  logic [26:0]        shifted;
  logic               lost;
  shift_pl_t          pl;

  assign exp_in     = i_stg.data.s_exp;
  assign shamt_full = 13'sd1 - exp_in;
  assign ext        = {i_stg.data.mant, i_stg.data.guard, i_stg.data.rnd, i_stg.data.sticky};

  always_comb begin
    shamt = (shamt_full >= DENORM_SHIFT_MAX) ? 6'(DENORM_SHIFT_MAX) : shamt_full[5:0];
    shifted = ext >> shamt;
    // Bits pushed out the bottom fold into sticky
    lost = |(ext & ~({27{1'b1}} << shamt));

    pl = '{d_sign: i_stg.data.d_sign, d_class: i_stg.data.d_class, s_exp: exp_in[9:0],
           mant: i_stg.data.mant, guard: i_stg.data.guard, rnd: i_stg.data.rnd,
           sticky: i_stg.data.sticky, s_sign: i_stg.data.s_sign,
           s_class: i_stg.data.s_class, w_exp: i_stg.data.w_exp, w_frac: i_stg.data.w_frac};

    if (exp_in <= 13'sd0) begin
      pl.s_exp  = 10'sd0;
      pl.mant   = shifted[26:3];
      pl.guard  = shifted[2];
      pl.rnd    = shifted[1];
      pl.sticky = shifted[0] | lost;
    end else if (exp_in >= 13'sd255) begin
      // Clamp so the rounder still sees overflow after the cut to 10 bits
      pl.s_exp = 10'sd255;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_stg.valid <= 1'b0;
    end else begin
      o_stg.valid <= i_stg.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_stg.valid) begin
      o_stg.op   <= i_stg.op;
      o_stg.rm   <= i_stg.rm;
      o_stg.data <= pl;
    end
  end

  exp_nonneg_a: assert property (@(posedge i_clk) disable iff (i_rst)
    o_stg.valid |-> !o_stg.data.s_exp[9])
    else $error("fp_cvt_denorm_shift: negative working exponent");

endmodule

// ==== fp_cvt_normalize.sv ====
`timescale 1ns/1ps

module fp_cvt_normalize (
  input logic     i_clk,
  input logic     i_rst,
  fp_stage_if.dst i_stg,
  fp_stage_if.src o_stg
);
  import fp_cvt_pkg::*;

  logic [52:0]         d_mant;
  logic signed [12:0]  d_exp_n;
  logic [23:0]         s_mant;
  logic [DP_EXP_W-1:0] w_exp;
  norm_pl_t            pl;

  // ==============================
  // Double operand, toward single
  // ==============================
  always_comb begin
    d_mant  = {1'b1, i_stg.data.d_frac};
    d_exp_n = i_stg.data.d_exp_sb;
    if (i_stg.data.d_subnorm) begin
      // Bring the leading one up to bit 52
      d_mant  = {1'b0, i_stg.data.d_frac} << (i_stg.data.d_lzc + 6'd1);
      // Exponent field 0 means 2^-1022, one above the rebiased field value
      d_exp_n = i_stg.data.d_exp_sb - 13'(i_stg.data.d_lzc);
    end
  end

  // ==============================
  // Single operand, toward double
  // ==============================
  always_comb begin
    s_mant = {1'b1, i_stg.data.s_frac};
    w_exp  = 11'(i_stg.data.s_exp) + 11'(DP_BIAS - SP_BIAS);
    if (i_stg.data.s_exp == '0) begin
      s_mant = {1'b0, i_stg.data.s_frac} << (i_stg.data.s_lzc + 5'd1);
      w_exp  = 11'(DP_BIAS - SP_BIAS) - 11'(i_stg.data.s_lzc);
    end
  end

  always_comb begin
    pl.d_sign  = i_stg.data.d_sign;
    pl.d_class = i_stg.data.d_class;
    pl.s_exp   = d_exp_n;
    // 24 kept bits including the hidden one
    pl.mant    = d_mant[52:29];
    pl.guard   = d_mant[28];
    pl.rnd     = d_mant[27];
    pl.sticky  = |d_mant[26:0];
    pl.s_sign  = i_stg.data.s_sign;
    pl.s_class = i_stg.data.s_class;
    pl.w_exp   = w_exp;
    // Widening is exact, the fraction is only zero padded
    pl.w_frac  = {s_mant[22:0], 29'd0};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_stg.valid <= 1'b0;
    end else begin
      o_stg.valid <= i_stg.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_stg.valid) begin
      o_stg.op   <= i_stg.op;
      o_stg.rm   <= i_stg.rm;
      o_stg.data <= pl;
    end
  end

endmodule

// ==== fp_cvt_pkg.sv ====
package fp_cvt_pkg;

  // ==============================
  // Format constants
  // ==============================
  localparam int FLEN      = 64;
  localparam int SP_EXP_W  = 8;
  localparam int SP_FRAC_W = 23;
  localparam int SP_BIAS   = 127;
  localparam int DP_EXP_W  = 11;
  localparam int DP_FRAC_W = 52;
  localparam int DP_BIAS   = 1023;

  // Positive quiet NaN with only the top fraction bit set
  localparam logic [31:0] SP_CANON_NAN = 32'h7fc0_0000;
  localparam logic [63:0] DP_CANON_NAN = 64'h7ff8_0000_0000_0000;

  // Mantissa, guard, round and sticky are 27 bits wide
  localparam int DENORM_SHIFT_MAX = 27;

  typedef enum logic {
    FCVT_S_D = 1'b0,
    FCVT_D_S = 1'b1
  } fcvt_op_e;

  // RISC-V frm encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } round_mode_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    logic zero;
    logic inf;
    logic nan;
    logic snan;
  } fp_class_t;

  // ==============================
  // Stage payloads
  // ==============================
  typedef struct packed {
    logic                 d_sign;
    logic [DP_FRAC_W-1:0] d_frac;
    logic                 d_subnorm;
    logic signed [12:0]   d_exp_sb;
    fp_class_t            d_class;
    logic [5:0]           d_lzc;
    logic                 s_sign;
    logic [SP_EXP_W-1:0]  s_exp;
    logic [SP_FRAC_W-1:0] s_frac;
    fp_class_t            s_class;
    logic [4:0]           s_lzc;
  } unpack_pl_t;

  typedef struct packed {
    logic                 d_sign;
    fp_class_t            d_class;
    logic signed [12:0]   s_exp;
    logic [23:0]          mant;
    logic                 guard;
    logic                 rnd;
    logic                 sticky;
    logic                 s_sign;
    fp_class_t            s_class;
    logic [DP_EXP_W-1:0]  w_exp;
    logic [DP_FRAC_W-1:0] w_frac;
  } norm_pl_t;

  typedef struct packed {
    logic                 d_sign;
    fp_class_t            d_class;
    logic signed [9:0]    s_exp;
    logic [23:0]          mant;
    logic                 guard;
    logic                 rnd;
    logic                 sticky;
    logic                 s_sign;
    fp_class_t            s_class;
    logic [DP_EXP_W-1:0]  w_exp;
    logic [DP_FRAC_W-1:0] w_frac;
  } shift_pl_t;

  typedef struct packed {
    logic [31:0]          s_res;
    fp_flags_t            s_flags;
    logic                 d_sign;
    fp_class_t            d_class;
    logic                 s_sign;
    fp_class_t            s_class;
    logic [DP_EXP_W-1:0]  w_exp;
    logic [DP_FRAC_W-1:0] w_frac;
  } round_pl_t;

endpackage

// ==== fp_cvt_result_select.sv ====
`timescale 1ns/1ps

module fp_cvt_result_select (
  input  logic                        i_clk,
  input  logic                        i_rst,
  fp_stage_if.dst                     i_stg,
  output logic                        o_valid,
  output logic [fp_cvt_pkg::FLEN-1:0] o_result,
  output fp_cvt_pkg::fp_flags_t       o_flags
);
  import fp_cvt_pkg::*;

  logic [31:0]     d2s_res;
  fp_flags_t       d2s_flags;
  logic [63:0]     s2d_res;
  fp_flags_t       s2d_flags;
  logic [FLEN-1:0] result;
  fp_flags_t       flags;

  // Double to single, specials take priority over the rounded value
  always_comb begin
    d2s_flags = '0;
    if (i_stg.data.d_class.nan) begin
      d2s_res      = SP_CANON_NAN;
      d2s_flags.nv = i_stg.data.d_class.snan;
    end else if (i_stg.data.d_class.inf) begin
      d2s_res = {i_stg.data.d_sign, 8'hff, 23'd0};
    end else if (i_stg.data.d_class.zero) begin
      d2s_res = {i_stg.data.d_sign, 31'd0};
    end else begin
      d2s_res   = i_stg.data.s_res;
      d2s_flags = i_stg.data.s_flags;
    end
  end

  // Single to double
  always_comb begin
    s2d_flags = '0;
    if (i_stg.data.s_class.nan) begin
      s2d_res      = DP_CANON_NAN;
      s2d_flags.nv = i_stg.data.s_class.snan;
    end else if (i_stg.data.s_class.inf) begin
      s2d_res = {i_stg.data.s_sign, 11'h7ff, 52'd0};
    end else if (i_stg.data.s_class.zero) begin
      s2d_res = {i_stg.data.s_sign, 63'd0};
    end else begin
      s2d_res = {i_stg.data.s_sign, i_stg.data.w_exp, i_stg.data.w_frac};
    end
  end

  // Single results are NaN-boxed
  assign result = (i_stg.op == FCVT_S_D) ? {{(FLEN-32){1'b1}}, d2s_res} : s2d_res;
  assign flags  = (i_stg.op == FCVT_S_D) ? d2s_flags : s2d_flags;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_stg.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_stg.valid) begin
      o_result <= result;
      o_flags  <= flags;
    end
  end

  no_dz_a: assert property (@(posedge i_clk) disable iff (i_rst) o_valid |-> !o_flags.dz)
    else $error("fp_cvt_result_select: divide-by-zero flag raised");

endmodule

// ==== fp_cvt_round.sv ====
`timescale 1ns/1ps

module fp_cvt_round (
  input logic     i_clk,
  input logic     i_rst,
  fp_stage_if.dst i_stg,
  fp_stage_if.src o_stg
);
  import fp_cvt_pkg::*;

  logic              sign;
  logic              inexact;
  logic              lsb;
  logic              round_up;
  logic              to_max;
  logic signed [9:0] exp_in;
  logic signed [9:0] exp_adj;
  logic [24:0]       mant_rnd;
  logic [22:0]       frac_out;
  logic [31:0]       res;
  fp_flags_t         flags;
  round_pl_t         pl;

  assign sign    = i_stg.data.d_sign;
  assign exp_in  = i_stg.data.s_exp;
  assign lsb     = i_stg.data.mant[0];
  assign inexact = i_stg.data.guard | i_stg.data.rnd | i_stg.data.sticky;

  always_comb begin
    case (i_stg.rm)
      RNE:     round_up = i_stg.data.guard & (i_stg.data.rnd | i_stg.data.sticky | lsb);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = sign & inexact;
      RUP:     round_up = ~sign & inexact;
      RMM:     round_up = i_stg.data.guard;
      default: round_up = 1'b0;
    endcase
  end

  assign mant_rnd = {1'b0, i_stg.data.mant} + 25'(round_up);

  always_comb begin
    frac_out = mant_rnd[22:0];
    exp_adj  = exp_in;
    if (mant_rnd[24]) begin
      exp_adj  = exp_in + 10'sd1;
      frac_out = mant_rnd[23:1];
    end else if (exp_in == 10'sd0) begin
      // Subnormal rounding into the hidden bit gives the smallest normal
      exp_adj = {9'd0, mant_rnd[23]};
    end
  end

  // Overflow saturates to the largest finite value when rounding toward it
  assign to_max = (i_stg.rm == RTZ) || ((i_stg.rm == RDN) && !sign) ||
                  ((i_stg.rm == RUP) && sign);

  always_comb begin
    flags = '0;
    if (exp_adj >= 10'sd255) begin
      flags.of = 1'b1;
      flags.nx = 1'b1;
      res = to_max ? {sign, 8'hfe, 23'h7f_ffff} : {sign, 8'hff, 23'd0};
    end else begin
      flags.nx = inexact;
      flags.uf = inexact && (exp_adj == 10'sd0);
      res      = {sign, exp_adj[7:0], frac_out};
    end
  end

  assign pl = '{s_res: res, s_flags: flags, d_sign: sign, d_class: i_stg.data.d_class,
                s_sign: i_stg.data.s_sign, s_class: i_stg.data.s_class,
                w_exp: i_stg.data.w_exp, w_frac: i_stg.data.w_frac};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_stg.valid <= 1'b0;
    end else begin
      o_stg.valid <= i_stg.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_stg.valid) begin
      o_stg.op   <= i_stg.op;
      o_stg.rm   <= i_stg.rm;
      o_stg.data <= pl;
    end
  end

endmodule

// ==== fp_cvt_tb.sv ====
`timescale 1ns/1ps

module fp_cvt_tb;
  import fp_cvt_pkg::*;

  localparam int N_DIRECTED  = 6;
  localparam int N_RANDOM    = 2000;
  localparam int N_OPS       = N_DIRECTED + N_RANDOM;
  localparam int TIMEOUT_CYC = (N_OPS + 20) * 2;

  typedef struct packed {
    logic [FLEN-1:0] res;
    fp_flags_t       flags;
    logic [31:0]     tag;
    logic            op;
    logic [2:0]      rm;
    logic [31:0]     s;
    logic [63:0]     d;
  } expect_t;

  logic            i_clk;
  logic            i_rst;
  logic            i_valid;
  logic [31:0]     i_operand_s;
  logic [FLEN-1:0] i_operand_d;
  fcvt_op_e        i_operation;
  logic [2:0]      i_rounding_mode;
  logic            o_valid;
  logic [FLEN-1:0] o_result;
  fp_flags_t       o_flags;

  logic [31:0]     rng;
  int unsigned     cyc;
  expect_t         exp_q[$];
  expect_t         ent;
  int              sent;
  logic [31:0]     r;

  fp_cvt_top dut0 (.*);

  always #5 i_clk = ~i_clk;

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first failure");
  endtask

  task automatic check_result(input logic [FLEN-1:0] got, input logic [FLEN-1:0] exp,
                              input string what);
    if (got !== exp)
      fail_run($sformatf("ERROR %0t: %s result %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("ERROR %0t: %s flags %b, expected %b", $time, what, got, exp));
  endtask

  // ==============================
  // Stimulus generation
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [63:0] rand_double();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [10:0] e;
    logic [51:0] f;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    f = {a[19:0], b};
    case (c[2:0])
      3'd0:    e = 11'd0;
      3'd1:    e = 11'h7ff;
      // Around the top of the single range
      3'd2:    e = 11'd1148 + 11'(c[10:8] % 5);
      // Around the bottom of the single range, into the subnormals
      3'd3:    e = 11'd866 + 11'(c[15:8] % 33);
      3'd4:    e = c[18:8];
      default: e = 11'd897 + 11'(c[15:8] % 254);
    endcase
    if (c[21:20] == 2'd0) f = '0;
    else if (c[23:22] == 2'd0) f[51:29] = '1;
    return {a[31], e, f};
  endfunction

  function automatic logic [31:0] rand_single();
    logic [31:0] a;
    logic [31:0] c;
    logic [7:0]  e;
    logic [22:0] f;
    a = next_rand();
    c = next_rand();
    case (c[1:0])
      2'd0:    e = 8'd0;
      2'd1:    e = 8'hff;
      default: e = c[9:2];
    endcase
    f = a[22:0];
    if (c[11:10] == 2'd0) f = '0;
    return {a[31], e, f};
  endfunction

  // ==============================
  // Reference model
  // ==============================
  task automatic model_convert(input fcvt_op_e op, input logic [2:0] rmc, input logic [31:0] s,
                               input logic [63:0] d, output logic [63:0] res,
                               output fp_flags_t fl);
    logic [2:0]  rm;
    logic        sg;
    logic [10:0] de;
    logic [51:0] df;
    logic [63:0] mm;
    logic [63:0] q;
    logic        g;
    logic        st;
    logic        inx;
    logic        up;
    logic [31:0] r32;
    int          top;
    int          eb;
    int          u;
    int          sh;
    int          bexp;
    fl = '0;
    rm = (rmc > 3'd4) ? 3'd0 : rmc;
    if (op == FCVT_D_S) begin
      if (s[30:23] == 8'hff && s[22:0] != '0) begin
        res   = DP_CANON_NAN;
        fl.nv = !s[22];
      end else if (s[30:23] == 8'hff) begin
        res = {s[31], 11'h7ff, 52'd0};
      end else if (s[30:0] == '0) begin
        res = {s[31], 63'd0};
      end else if (s[30:23] != '0) begin
        res = {s[31], 11'(s[30:23]) + 11'd896, s[22:0], 29'd0};
      end else begin
        // Subnormal single, value is frac times 2^-149
        top = 0;
        for (int i = 0; i < 23; i++) if (s[i]) top = i;
        q   = (64'(s[22:0]) << (52 - top)) & 64'h000f_ffff_ffff_ffff;
        res = {s[31], 11'(top + 874), q[51:0]};
      end
    end else begin
      sg = d[63];
      de = d[62:52];
      df = d[51:0];
      if (de == 11'h7ff && df != '0) begin
        r32   = SP_CANON_NAN;
        fl.nv = !df[51];
      end else if (de == 11'h7ff) begin
        r32 = {sg, 8'hff, 23'd0};
      end else if (de == '0 && df == '0) begin
        r32 = {sg, 31'd0};
      end else begin
        mm  = {11'd0, de != '0, df};
        top = 0;
        for (int i = 0; i < 53; i++) if (mm[i]) top = i;
        // Exponent of mantissa bit 0, then the unit in the last place of the single
        eb = (de != '0) ? int'(de) - 1075 : -1074;
        u  = ((eb + top < -126) ? -126 : eb + top) - 23;
        sh = u - eb;
        if (sh > 55) sh = 55;
        q   = mm >> sh;
        g   = mm[sh-1];
        st  = |(mm & ((64'd1 << (sh - 1)) - 64'd1));
        inx = g | st;
        case (rm)
          3'd0:    up = g & (st | q[0]);
          3'd1:    up = 1'b0;
          3'd2:    up = sg & inx;
          3'd3:    up = !sg & inx;
          default: up = g;
        endcase
        q = q + 64'(up);
        if (q[24]) begin
          q = q >> 1;
          u = u + 1;
        end
        bexp  = q[23] ? u + 150 : 0;
        fl.nx = inx;
        if (bexp >= 255) begin
          fl.of = 1'b1;
          fl.nx = 1'b1;
          if (rm == 3'd1 || (rm == 3'd2 && !sg) || (rm == 3'd3 && sg))
            r32 = {sg, 8'hfe, 23'h7f_ffff};
          else
            r32 = {sg, 8'hff, 23'd0};
        end else begin
          fl.uf = inx && (bexp == 0);
          r32   = {sg, 8'(bexp), q[22:0]};
        end
      end
      res = {32'hffff_ffff, r32};
    end
  endtask

  task automatic drive_op(input fcvt_op_e op, input logic [2:0] rm, input logic [31:0] s,
                          input logic [63:0] d);
    @(posedge i_clk);
    i_valid         <= 1'b1;
    i_operation     <= op;
    i_rounding_mode <= rm;
    i_operand_s     <= s;
    i_operand_d     <= d;
  endtask

  task automatic idle_cycle();
    @(posedge i_clk);
    i_valid <= 1'b0;
  endtask

  always @(posedge i_clk) begin
    if (cyc >= TIMEOUT_CYC)
      fail_run($sformatf("Timeout after %0d cycles, outputs stopped arriving", cyc));
    else
      cyc <= cyc + 1;
  end

  // Outputs and accepted inputs are both sampled mid-cycle
  always @(negedge i_clk) begin
    if (!i_rst && $isunknown(o_valid)) begin
      fail_run("Output valid is unknown after reset");
    end else if (!i_rst && o_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("An output arrived with no operation outstanding");
      end else begin
        ent = exp_q.pop_front();
        if (cyc - ent.tag != 5) begin
          fail_run($sformatf("Output arrived %0d cycles after its input instead of 5",
                             cyc - ent.tag));
        end else begin
          check_result(o_result, ent.res, $sformatf("op %0d rm %0d s %h d %h",
                       ent.op, ent.rm, ent.s, ent.d));
          check_flags(o_flags, ent.flags, $sformatf("op %0d rm %0d s %h d %h",
                      ent.op, ent.rm, ent.s, ent.d));
        end
      end
    end
    if (!i_rst && i_valid) begin
      model_convert(i_operation, i_rounding_mode, i_operand_s, i_operand_d, ent.res, ent.flags);
      ent.tag = cyc;
      ent.op  = i_operation;
      ent.rm  = i_rounding_mode;
      ent.s   = i_operand_s;
      ent.d   = i_operand_d;
      exp_q.push_back(ent);
    end
  end

  initial begin
    i_clk           = 1'b0;
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand_s     = '0;
    i_operand_d     = '0;
    i_operation     = FCVT_S_D;
    i_rounding_mode = 3'd0;
    rng             = 32'hfd8b;
    cyc             = 0;
    sent            = 0;
    repeat (5) @(posedge i_clk);
    i_rst <= 1'b0;
    // Quiet cycles, no output may show up here
    repeat (3) idle_cycle();
    drive_op(FCVT_S_D, 3'd3, 32'd0, 64'h0000_0000_0000_0001);
    drive_op(FCVT_S_D, 3'd0, 32'd0, 64'h3ff0_0000_0000_0000);
    drive_op(FCVT_S_D, 3'd1, 32'd0, 64'h7fe0_0000_0000_0000);
    drive_op(FCVT_D_S, 3'd0, 32'h0000_0001, 64'd0);
    drive_op(FCVT_D_S, 3'd0, 32'h7f80_0001, 64'd0);
    drive_op(FCVT_S_D, 3'd2, 32'd0, 64'hfff0_0000_0000_0000);
    while (sent < N_RANDOM) begin
      r = next_rand();
      if (r[1:0] != 2'b00) begin
        drive_op(fcvt_op_e'(r[2]), r[5:3], rand_single(), rand_double());
        sent++;
      end else begin
        idle_cycle();
      end
    end
    idle_cycle();
    // The last result is due five cycles after its input
    repeat (8) @(posedge i_clk);
    if (exp_q.size() != 0) begin
      fail_run("Operations were still outstanding at the end of the run");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== fp_cvt_top.sv ====
`timescale 1ns/1ps

module fp_cvt_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  input  logic [31:0]                 i_operand_s,
  input  logic [fp_cvt_pkg::FLEN-1:0] i_operand_d,
  input  fp_cvt_pkg::fcvt_op_e        i_operation,
  input  logic [2:0]                  i_rounding_mode,
  output logic                        o_valid,
  output logic [fp_cvt_pkg::FLEN-1:0] o_result,
  output fp_cvt_pkg::fp_flags_t       o_flags
);
  import fp_cvt_pkg::*;

  // ==============================
  // Stage boundaries
  // ==============================
  fp_stage_if #(.payload_t(unpack_pl_t)) stg1 ();
  fp_stage_if #(.payload_t(norm_pl_t))   stg2 ();
  fp_stage_if #(.payload_t(shift_pl_t))  stg3 ();
  fp_stage_if #(.payload_t(round_pl_t))  stg4 ();

  // ==============================
  // Five-stage pipeline
  // ==============================
  fp_cvt_unpack u_unpack (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand_s     (i_operand_s),
    .i_operand_d     (i_operand_d),
    .i_operation     (i_operation),
    .i_rounding_mode (i_rounding_mode),
    .o_stg           (stg1.src)
  );

  fp_cvt_normalize u_normalize (.i_clk(i_clk), .i_rst(i_rst), .i_stg(stg1.dst), .o_stg(stg2.src));

  fp_cvt_denorm_shift u_denorm (.i_clk(i_clk), .i_rst(i_rst), .i_stg(stg2.dst), .o_stg(stg3.src));

  fp_cvt_round u_round (.i_clk(i_clk), .i_rst(i_rst), .i_stg(stg3.dst), .o_stg(stg4.src));

  fp_cvt_result_select u_result (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_stg    (stg4.dst),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

endmodule

// ==== fp_cvt_unpack.sv ====
`timescale 1ns/1ps

module fp_cvt_unpack (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  input  logic [31:0]                 i_operand_s,
  input  logic [fp_cvt_pkg::FLEN-1:0] i_operand_d,
  input  fp_cvt_pkg::fcvt_op_e        i_operation,
  input  logic [2:0]                  i_rounding_mode,
  fp_stage_if.src                     o_stg
);
  import fp_cvt_pkg::*;

  logic [DP_EXP_W-1:0]  d_exp;
  logic [DP_FRAC_W-1:0] d_frac;
  logic [SP_EXP_W-1:0]  s_exp;
  logic [SP_FRAC_W-1:0] s_frac;
  logic [5:0]           s_lzc_full;
  round_mode_e          rm;
  unpack_pl_t           pl;

  // Leading zeros of a 52-bit field, 52 when it is all zero
  function automatic logic [5:0] lzc52(input logic [51:0] frac);
    logic [5:0] cnt;
    logic       found;
    cnt   = '0;
    found = 1'b0;
    for (int i = 51; i >= 0; i--) begin
      if (!found) begin
        if (frac[i]) found = 1'b1;
        else cnt = cnt + 6'd1;
      end
    end
    return cnt;
  endfunction

  assign d_exp  = i_operand_d[FLEN-2 -: DP_EXP_W];
  assign d_frac = i_operand_d[DP_FRAC_W-1:0];
  assign s_exp  = i_operand_s[30 -: SP_EXP_W];
  assign s_frac = i_operand_s[SP_FRAC_W-1:0];

  // Single fraction padded with a stop bit so the same counter serves both
  assign s_lzc_full = lzc52({s_frac, 1'b1, 28'd0});

  // Reserved frm codes fall back to RNE
  assign rm = (i_rounding_mode > 3'd4) ? RNE : round_mode_e'(i_rounding_mode);

  always_comb begin
    pl.d_sign       = i_operand_d[FLEN-1];
    pl.d_frac       = d_frac;
    pl.d_subnorm    = (d_exp == '0) && (d_frac != '0);
    pl.d_exp_sb     = 13'(d_exp) - 13'(DP_BIAS - SP_BIAS);
    pl.d_class.zero = (d_exp == '0) && (d_frac == '0);
    pl.d_class.inf  = (&d_exp) && (d_frac == '0);
    pl.d_class.nan  = (&d_exp) && (d_frac != '0);
    pl.d_class.snan = (&d_exp) && (d_frac != '0) && !d_frac[DP_FRAC_W-1];
    pl.d_lzc        = lzc52(d_frac);
    pl.s_sign       = i_operand_s[31];
    pl.s_exp        = s_exp;
    pl.s_frac       = s_frac;
    pl.s_class.zero = (s_exp == '0) && (s_frac == '0);
    pl.s_class.inf  = (&s_exp) && (s_frac == '0);
    pl.s_class.nan  = (&s_exp) && (s_frac != '0);
    pl.s_class.snan = (&s_exp) && (s_frac != '0) && !s_frac[SP_FRAC_W-1];
    pl.s_lzc        = s_lzc_full[4:0];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_stg.valid <= 1'b0;
    end else begin
      o_stg.valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_stg.op   <= i_operation;
      o_stg.rm   <= rm;
      o_stg.data <= pl;
    end
  end

  op_known_a: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> !$isunknown(i_operation))
    else $error("fp_cvt_unpack: operation unknown while valid");

endmodule

// ==== fp_stage_if.sv ====
`timescale 1ns/1ps

// One pipeline stage boundary, valid-only handshake with no ready
interface fp_stage_if #(
  parameter type payload_t = logic
) ();
  import fp_cvt_pkg::*;

  logic        valid;
  fcvt_op_e    op;
  round_mode_e rm;
  // Meaningful only while valid is high
  payload_t    data;

  modport src (
    output valid, op, rm, data
  );

  modport dst (
    input valid, op, rm, data
  );

endinterface
